/* frontend_consts.svh */
`ifndef FRONTEND_CONSTS_SVH
`define FRONTEND_CONSTS_SVH

// First fetch address after reset
`define RESET_PC 32'h0000_0000

// 16 direct-mapped entries, indexed by pc[5:2]
`define BTB_IDX_BITS 4

// Return address stack entries
`define RAS_DEPTH 4

// 256 instruction words, indexed by pc[9:2]
`define MEM_ADDR_BITS 8

`endif

/* frontend_pkg.sv */
package frontend_pkg;

    // Instruction word
    typedef logic [31:0] u32_t;

    // Virtual fetch address
    typedef logic [31:0] virt_t;

    // Major opcodes of the branch family, inst[31:26]
    typedef enum logic [5:0] {
        OP_JIRL = 6'b010011,
        OP_B    = 6'b010100,
        OP_BL   = 6'b010101,
        OP_BEQ  = 6'b010110,
        OP_BNE  = 6'b010111,
        OP_BLT  = 6'b011000,
        OP_BGE  = 6'b011001,
        OP_BLTU = 6'b011010,
        OP_BGEU = 6'b011011
    } br_op_t;

endpackage

/* btb.sv */
`timescale 1ns/1ps
`include "frontend_consts.svh"

module btb (
    input  logic                clk,
    input  logic                rst_n,
    input  frontend_pkg::virt_t lookup_pc,
    output logic                hit,
    output frontend_pkg::virt_t target,
    input  logic                train_valid,
    input  frontend_pkg::virt_t train_pc,
    input  frontend_pkg::virt_t train_target,
    input  logic                inv_valid,
    input  frontend_pkg::virt_t inv_pc
);
    import frontend_pkg::*;

    localparam int IDX_W   = `BTB_IDX_BITS;
    localparam int ENTRIES = 1 << IDX_W;
    localparam int TAG_W   = 30 - IDX_W;

    logic [ENTRIES-1:0] valid_r;
    logic [TAG_W-1:0]   tag_r [ENTRIES];
    virt_t              target_r [ENTRIES];

    logic [IDX_W-1:0] lk_idx;
    logic [IDX_W-1:0] tr_idx;
    logic [IDX_W-1:0] inv_idx;

    assign lk_idx  = lookup_pc[IDX_W+1:2];
    assign tr_idx  = train_pc[IDX_W+1:2];
    assign inv_idx = inv_pc[IDX_W+1:2];

    assign hit    = valid_r[lk_idx] && (tag_r[lk_idx] == lookup_pc[31:IDX_W+2]);
    assign target = target_r[lk_idx];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_r <= '0;
        end else begin
            if (train_valid) begin
                valid_r[tr_idx] <= 1'b1;
            end
            // Invalidation wins over training on the same entry
            if (inv_valid) begin
                valid_r[inv_idx] <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (train_valid) begin
            tag_r[tr_idx]    <= train_pc[31:IDX_W+2];
            target_r[tr_idx] <= train_target;
        end
    end

endmodule

/* ras.sv */
`timescale 1ns/1ps
`include "frontend_consts.svh"

module ras (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                push,
    input  logic                pop,
    input  frontend_pkg::virt_t push_addr,
    output frontend_pkg::virt_t ra,
    output logic                ra_valid
);
    import frontend_pkg::*;

    localparam int PTR_W = $clog2(`RAS_DEPTH);
    localparam int CNT_W = $clog2(`RAS_DEPTH + 1);

    virt_t            stack_r [`RAS_DEPTH];
    logic [PTR_W-1:0] top_r;
    logic [PTR_W-1:0] top_up;
    logic [PTR_W-1:0] top_dn;
    logic [CNT_W-1:0] cnt_r;
    logic             pop_ok;

    // Circular pointer steps
    assign top_up = (top_r == PTR_W'(`RAS_DEPTH - 1)) ? '0 : top_r + 1'b1;
    assign top_dn = (top_r == '0) ? PTR_W'(`RAS_DEPTH - 1) : top_r - 1'b1;

    assign pop_ok   = pop && (cnt_r != '0);
    assign ra       = stack_r[top_r];
    assign ra_valid = (cnt_r != '0);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            top_r <= '0;
            cnt_r <= '0;
        end else if (push && !pop_ok) begin
            top_r <= top_up;
            // Full stack drops its oldest entry
            if (cnt_r != CNT_W'(`RAS_DEPTH)) begin
                cnt_r <= cnt_r + 1'b1;
            end
        end else if (pop_ok && !push) begin
            top_r <= top_dn;
            cnt_r <= cnt_r - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (push && pop_ok) begin
            stack_r[top_r] <= push_addr;
        end else if (push) begin
            stack_r[top_up] <= push_addr;
        end
    end

endmodule

/* inst_mem.sv */
`timescale 1ns/1ps
`include "frontend_consts.svh"

module inst_mem (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                rd_valid,
    input  logic                rd_ready,
    input  frontend_pkg::virt_t rd_pc,
    output frontend_pkg::u32_t  data,
    output logic                data_valid,
    input  logic                load_valid,
    input  frontend_pkg::virt_t load_addr,
    input  frontend_pkg::u32_t  load_data
);
    import frontend_pkg::*;

    localparam int AW    = `MEM_ADDR_BITS;
    localparam int WORDS = 1 << AW;

    u32_t          mem_r [WORDS];
    logic [AW-1:0] rd_idx;
    logic [AW-1:0] ld_idx;
    logic          rd_fire;

    assign rd_idx  = rd_pc[AW+1:2];
    assign ld_idx  = load_addr[AW+1:2];
    assign rd_fire = rd_valid && rd_ready;

    always_ff @(posedge clk) begin
        if (load_valid) begin
            mem_r[ld_idx] <= load_data;
        end
        // Read data holds while the consumer stalls
        if (rd_fire) begin
            data <= mem_r[rd_idx];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            data_valid <= 1'b0;
        end else if (rd_fire) begin
            data_valid <= 1'b1;
        end
    end

endmodule

/* pc_gen.sv */
`timescale 1ns/1ps
`include "frontend_consts.svh"

module pc_gen (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                flush,
    input  frontend_pkg::virt_t flush_pc,
    input  logic                redirect_valid,
    input  frontend_pkg::virt_t redirect_pc,
    input  logic                redirect_predict,
    input  logic                train_valid,
    input  frontend_pkg::virt_t train_pc,
    input  frontend_pkg::virt_t train_target,
    input  logic                inv_valid,
    input  frontend_pkg::virt_t inv_pc,
    input  logic                rd_ready,
    output logic                rd_valid,
    output frontend_pkg::virt_t rd_pc,
    output frontend_pkg::virt_t next_pc,
    output frontend_pkg::virt_t f1_pc,
    output logic                f1_valid,
    output logic                f1_predict
);
    import frontend_pkg::*;

    virt_t pc_r;
    logic  run_r;
    logic  ras_tgt_r;
    logic  btb_hit;
    virt_t btb_target;
    logic  use_btb;

    btb btb_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .lookup_pc    (pc_r),
        .hit          (btb_hit),
        .target       (btb_target),
        .train_valid  (train_valid),
        .train_pc     (train_pc),
        .train_target (train_target),
        .inv_valid    (inv_valid),
        .inv_pc       (inv_pc)
    );

    // A PC taken from the RAS is already a prediction, fetch on from it sequentially
    assign use_btb = btb_hit && !ras_tgt_r;
    assign next_pc = use_btb ? btb_target : pc_r + 32'd4;

    assign rd_valid   = run_r;
    assign rd_pc      = pc_r;
    assign f1_valid   = run_r;
    assign f1_pc      = pc_r;
    assign f1_predict = use_btb;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc_r      <= `RESET_PC;
            run_r     <= 1'b0;
            ras_tgt_r <= 1'b0;
        end else begin
            run_r <= 1'b1;
            // Back-end flush first, then fetch2 redirect, then the prediction
            if (flush) begin
                pc_r      <= flush_pc;
                ras_tgt_r <= 1'b0;
            end else if (redirect_valid) begin
                pc_r      <= redirect_pc;
                ras_tgt_r <= redirect_predict;
            end else if (rd_valid && rd_ready) begin
                pc_r      <= next_pc;
                ras_tgt_r <= 1'b0;
            end
        end
    end

endmodule

/* fetch2.sv */
`timescale 1ns/1ps

module fetch2 (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                flush,
    input  logic                f1_valid,
    input  logic                f1_predict,
    input  frontend_pkg::virt_t f1_pc,
    input  frontend_pkg::virt_t f1_next_pc,
    input  frontend_pkg::u32_t  mem_data,
    input  logic                mem_data_valid,
    output logic                rdy_in,
    input  logic                out_ready,
    output logic                out_valid,
    output frontend_pkg::u32_t  out_inst,
    output frontend_pkg::virt_t out_pc,
    output frontend_pkg::virt_t out_next_pc,
    output logic                out_predict,
    output logic                redirect_valid,
    output frontend_pkg::virt_t redirect_pc,
    output logic                redirect_predict,
    output logic                inv_valid,
    output frontend_pkg::virt_t inv_pc
);
    import frontend_pkg::*;

    logic   valid_r;
    logic   pred_r;
    virt_t  pc_r;
    virt_t  next_r;
    virt_t  seq_pc;
    logic   if2_flush;
    logic   if2_stall;
    logic   working;
    br_op_t op;
    logic   is_b;
    logic   is_bl;
    logic   is_jirl;
    logic   is_cond;
    logic   is_br;
    logic   is_return;
    logic   bp_error;
    logic   bp_advance;
    logic   bp_repredict;
    virt_t  jump_to;
    virt_t  ra;
    logic   ra_valid;

    // Redirected younger item is dropped on capture
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_r <= 1'b0;
        end else if (rdy_in) begin
            valid_r <= f1_valid && !flush && !redirect_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (rdy_in) begin
            pc_r   <= f1_pc;
            next_r <= f1_next_pc;
            pred_r <= f1_predict;
        end
    end

    assign if2_flush = flush || !valid_r;
    assign if2_stall = !out_ready || !mem_data_valid;
    assign rdy_in    = if2_flush || !if2_stall;
    assign working   = !if2_flush && !if2_stall;

    // Pre-decode of the major opcode
    assign op = br_op_t'(mem_data[31:26]);

    always_comb begin
        is_b    = 1'b0;
        is_bl   = 1'b0;
        is_jirl = 1'b0;
        is_cond = 1'b0;
        case (op)
            OP_JIRL: is_jirl = 1'b1;
            OP_B:    is_b    = 1'b1;
            OP_BL:   is_bl   = 1'b1;
            OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU: is_cond = 1'b1;
            default: ;
        endcase
    end

    assign is_br     = is_b || is_bl || is_jirl || is_cond;
    // jirl r0, r1, 0
    assign is_return = (mem_data == {OP_JIRL, 16'b0, 5'b00001, 5'b0});

    assign seq_pc  = pc_r + 32'd4;
    assign jump_to = pc_r + {{4{mem_data[9]}}, mem_data[9:0], mem_data[25:10], 2'b0};

    assign bp_error     = working && !is_br && pred_r && (next_r != seq_pc);
    assign bp_advance   = working && (is_b || is_bl);
    assign bp_repredict = working && is_return && ra_valid;

    ras ras_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .push      (working && is_bl),
        .pop       (bp_repredict),
        .push_addr (seq_pc),
        .ra        (ra),
        .ra_valid  (ra_valid)
    );

    always_comb begin
        redirect_valid   = 1'b1;
        redirect_pc      = seq_pc;
        redirect_predict = 1'b0;
        if (bp_error) begin
            redirect_pc = seq_pc;
        end else if (bp_advance) begin
            redirect_pc = jump_to;
        end else if (bp_repredict) begin
            redirect_pc      = ra;
            redirect_predict = 1'b1;
        end else begin
            redirect_valid = 1'b0;
        end
    end

    assign out_valid   = working;
    assign out_inst    = mem_data;
    assign out_pc      = pc_r;
    assign out_next_pc = redirect_valid ? redirect_pc : next_r;
    assign out_predict = redirect_valid ? redirect_predict : pred_r;

    assign inv_valid = bp_error;
    assign inv_pc    = pc_r;

endmodule

/* frontend_top.sv */
`timescale 1ns/1ps

module frontend_top (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                flush,
    input  frontend_pkg::virt_t flush_pc,
    input  logic                train_valid,
    input  frontend_pkg::virt_t train_pc,
    input  frontend_pkg::virt_t train_target,
    input  logic                load_valid,
    input  frontend_pkg::virt_t load_addr,
    input  frontend_pkg::u32_t  load_data,
    output logic                out_valid,
    output frontend_pkg::u32_t  out_inst,
    output frontend_pkg::virt_t out_pc,
    output frontend_pkg::virt_t out_next_pc,
    output logic                out_predict,
    input  logic                out_ready
);
    import frontend_pkg::*;

    logic  rd_valid;
    logic  rd_ready;
    virt_t rd_pc;
    logic  f1_valid;
    logic  f1_predict;
    virt_t f1_pc;
    virt_t f1_next_pc;
    u32_t  mem_data;
    logic  mem_data_valid;
    logic  redirect_valid;
    virt_t redirect_pc;
    logic  redirect_predict;
    logic  inv_valid;
    virt_t inv_pc;

    pc_gen pc_gen_inst (
        .clk              (clk),
        .rst_n            (rst_n),
        .flush            (flush),
        .flush_pc         (flush_pc),
        .redirect_valid   (redirect_valid),
        .redirect_pc      (redirect_pc),
        .redirect_predict (redirect_predict),
        .train_valid      (train_valid),
        .train_pc         (train_pc),
        .train_target     (train_target),
        .inv_valid        (inv_valid),
        .inv_pc           (inv_pc),
        .rd_ready         (rd_ready),
        .rd_valid         (rd_valid),
        .rd_pc            (rd_pc),
        .next_pc          (f1_next_pc),
        .f1_pc            (f1_pc),
        .f1_valid         (f1_valid),
        .f1_predict       (f1_predict)
    );

    inst_mem inst_mem_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .rd_valid   (rd_valid),
        .rd_ready   (rd_ready),
        .rd_pc      (rd_pc),
        .data       (mem_data),
        .data_valid (mem_data_valid),
        .load_valid (load_valid),
        .load_addr  (load_addr),
        .load_data  (load_data)
    );

    // Memory read and fetch2 capture share one ready
    fetch2 fetch2_inst (
        .clk              (clk),
        .rst_n            (rst_n),
        .flush            (flush),
        .f1_valid         (f1_valid),
        .f1_predict       (f1_predict),
        .f1_pc            (f1_pc),
        .f1_next_pc       (f1_next_pc),
        .mem_data         (mem_data),
        .mem_data_valid   (mem_data_valid),
        .rdy_in           (rd_ready),
        .out_ready        (out_ready),
        .out_valid        (out_valid),
        .out_inst         (out_inst),
        .out_pc           (out_pc),
        .out_next_pc      (out_next_pc),
        .out_predict      (out_predict),
        .redirect_valid   (redirect_valid),
        .redirect_pc      (redirect_pc),
        .redirect_predict (redirect_predict),
        .inv_valid        (inv_valid),
        .inv_pc           (inv_pc)
    );

endmodule

/* frontend_checker.sv */
`timescale 1ns/1ps
`include "frontend_consts.svh"

module frontend_checker (
    input  logic                clk,
    input  logic                rst_n,
    input  logic [2:0]          test_id,
    input  logic                flush,
    input  frontend_pkg::virt_t flush_pc,
    input  logic                train_valid,
    input  frontend_pkg::virt_t train_pc,
    input  frontend_pkg::virt_t train_target,
    input  logic                load_valid,
    input  frontend_pkg::virt_t load_addr,
    input  frontend_pkg::u32_t  load_data,
    input  logic                out_valid,
    input  logic                out_ready,
    input  frontend_pkg::u32_t  out_inst,
    input  frontend_pkg::virt_t out_pc,
    input  frontend_pkg::virt_t out_next_pc,
    input  logic                out_predict,
    input  logic                inv_valid,
    output int                  err_count
);
    import frontend_pkg::*;

    localparam int   WORDS    = 1 << `MEM_ADDR_BITS;
    localparam int   ENTRIES  = 1 << `BTB_IDX_BITS;
    localparam u32_t RET_WORD = {6'b010011, 16'h0000, 5'd1, 5'd0};

    u32_t  prog [WORDS];
    virt_t stack [$];
    logic  mbtb_valid [ENTRIES];
    virt_t mbtb_pc [ENTRIES];
    virt_t mbtb_target [ENTRIES];
    logic  armed;
    virt_t exp_pc;
    virt_t exp_next;
    virt_t stk_top;
    u32_t  exp_inst;
    logic  exp_inv;
    logic  exp_hit;
    logic  exp_pred;
    logic  stk_ok;
    int    idx;

    function automatic string test_label(input logic [2:0] id);
        case (id)
            3'd1:    return "straight_line";
            3'd2:    return "jumps";
            3'd3:    return "call_return";
            3'd4:    return "stale_btb";
            3'd5:    return "flush";
            default: return "setup";
        endcase
    endfunction

    // Branch family occupies opcodes 010011 through 011011
    function automatic logic is_branch(input u32_t inst);
        return (inst[31:26] >= 6'b010011) && (inst[31:26] <= 6'b011011);
    endfunction

    // Architectural next fetch address of the walk
    function automatic virt_t ref_next(input virt_t pc, input u32_t inst,
                                       input logic have_ra, input virt_t ra_top);
        logic [25:0] offs26;
        int          delta;
        // Low offset half sits in inst[25:10], high half in inst[9:0]
        offs26 = {inst[9:0], inst[25:10]};
        delta  = $signed({offs26, 2'b00});
        if (inst[31:26] == OP_B || inst[31:26] == OP_BL) begin
            return pc + delta;
        end
        if (inst == RET_WORD && have_ra) begin
            return ra_top;
        end
        return pc + 32'd4;
    endfunction

    // Predicted flag that goes with the decode item
    function automatic logic ref_predict(input u32_t inst, input logic have_ra,
                                         input logic btb_hit, input logic wrong);
        if (inst[31:26] == OP_B || inst[31:26] == OP_BL) begin
            return 1'b0;
        end
        if (inst == RET_WORD && have_ra) begin
            return 1'b1;
        end
        return btb_hit && !wrong;
    endfunction

    task automatic report(input string field, input logic [31:0] exp, input logic [31:0] act);
        $display("ERR %s: %s expected %h, actual %h", test_label(test_id), field, exp, act);
        err_count++;
    endtask

    initial begin
        err_count = 0;
        armed     = 1'b0;
    end

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            armed  = 1'b1;
            exp_pc = `RESET_PC;
            stack.delete();
            for (idx = 0; idx < ENTRIES; idx++) begin
                mbtb_valid[idx] = 1'b0;
            end
        end else begin
            if (load_valid) begin
                prog[load_addr[`MEM_ADDR_BITS+1:2]] = load_data;
            end
            if (armed) begin
                exp_inv = 1'b0;
                if (out_valid && out_ready) begin
                    exp_inst = prog[exp_pc[`MEM_ADDR_BITS+1:2]];
                    stk_ok   = (stack.size() != 0);
                    stk_top  = '0;
                    if (stk_ok) begin
                        stk_top = stack[$];
                    end
                    exp_next = ref_next(exp_pc, exp_inst, stk_ok, stk_top);
                    // A trained entry on a non-branch is a wrong prediction
                    idx     = exp_pc[`BTB_IDX_BITS+1:2];
                    exp_hit = mbtb_valid[idx] && (mbtb_pc[idx] == exp_pc);
                    if (exp_hit && !is_branch(exp_inst)
                        && mbtb_target[idx] != exp_pc + 32'd4) begin
                        exp_inv         = 1'b1;
                        mbtb_valid[idx] = 1'b0;
                    end
                    exp_pred = ref_predict(exp_inst, stk_ok, exp_hit, exp_inv);
                    if (out_pc !== exp_pc) begin
                        report("out_pc", exp_pc, out_pc);
                    end
                    if (out_inst !== exp_inst) begin
                        report("out_inst", exp_inst, out_inst);
                    end
                    if (out_next_pc !== exp_next) begin
                        report("out_next_pc", exp_next, out_next_pc);
                    end
                    if (out_predict !== exp_pred) begin
                        report("out_predict", {31'b0, exp_pred}, {31'b0, out_predict});
                    end
                    // Model stack drops its oldest entry when full
                    if (exp_inst[31:26] == OP_BL) begin
                        if (stack.size() == `RAS_DEPTH) begin
                            stack.delete(0);
                        end
                        stack.push_back(exp_pc + 32'd4);
                    end else if (exp_inst == RET_WORD && stk_ok) begin
                        stack.delete(stack.size() - 1);
                    end
                    exp_pc = exp_next;
                end
                if (inv_valid !== exp_inv) begin
                    report("inv_valid", {31'b0, exp_inv}, {31'b0, inv_valid});
                end
                if (train_valid) begin
                    idx              = train_pc[`BTB_IDX_BITS+1:2];
                    mbtb_valid[idx]  = 1'b1;
                    mbtb_pc[idx]     = train_pc;
                    mbtb_target[idx] = train_target;
                end
                if (flush) begin
                    exp_pc = flush_pc;
                end
            end
        end
    end

endmodule

/* tb_frontend.sv */
`timescale 1ns/1ps
`include "frontend_consts.svh"

module tb_frontend;
    import frontend_pkg::*;

    localparam int   WORDS    = 1 << `MEM_ADDR_BITS;
    localparam u32_t RET_WORD = {6'b010011, 16'h0000, 5'd1, 5'd0};

    logic       clk;
    logic       rst_n;
    logic       flush;
    virt_t      flush_pc;
    logic       train_valid;
    virt_t      train_pc;
    virt_t      train_target;
    logic       load_valid;
    virt_t      load_addr;
    u32_t       load_data;
    logic       out_valid;
    u32_t       out_inst;
    virt_t      out_pc;
    virt_t      out_next_pc;
    logic       out_predict;
    logic       out_ready;
    logic       inv_seen;
    logic [2:0] test_id;
    logic       ready_en;
    logic       timed_out;
    int         timeouts;
    int         err_count;
    int         seed;
    int         k;
    u32_t       image [WORDS];

    frontend_top frontend_top_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .flush        (flush),
        .flush_pc     (flush_pc),
        .train_valid  (train_valid),
        .train_pc     (train_pc),
        .train_target (train_target),
        .load_valid   (load_valid),
        .load_addr    (load_addr),
        .load_data    (load_data),
        .out_valid    (out_valid),
        .out_inst     (out_inst),
        .out_pc       (out_pc),
        .out_next_pc  (out_next_pc),
        .out_predict  (out_predict),
        .out_ready    (out_ready)
    );

    assign inv_seen = frontend_top_inst.inv_valid;

    frontend_checker checker_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .test_id      (test_id),
        .flush        (flush),
        .flush_pc     (flush_pc),
        .train_valid  (train_valid),
        .train_pc     (train_pc),
        .train_target (train_target),
        .load_valid   (load_valid),
        .load_addr    (load_addr),
        .load_data    (load_data),
        .out_valid    (out_valid),
        .out_ready    (out_ready),
        .out_inst     (out_inst),
        .out_pc       (out_pc),
        .out_next_pc  (out_next_pc),
        .out_predict  (out_predict),
        .inv_valid    (inv_seen),
        .err_count    (err_count)
    );

    always #50 clk = ~clk;

    // Decode accepts about three cycles in four
    always @(negedge clk) begin
        if (ready_en) begin
            out_ready = (($random(seed) & 32'h3) != 0);
        end
    end

    function automatic u32_t enc_jump(input logic [5:0] op, input virt_t pc, input virt_t target);
        virt_t       diff;
        logic [25:0] offs;
        diff = target - pc;
        offs = diff[27:2];
        return {op, offs[15:0], offs[25:16]};
    endfunction

    function automatic int word_of(input virt_t addr);
        return addr[`MEM_ADDR_BITS+1:2];
    endfunction

    // Non-branch filler that carries its own address
    task automatic build_image();
        int i;
        for (i = 0; i < WORDS; i++) begin
            image[i] = 32'h0340_0000 | (i << 2);
        end
        image[word_of(32'h040)] = enc_jump(OP_B, 32'h040, 32'h040);
        image[word_of(32'h104)] = enc_jump(OP_B, 32'h104, 32'h140);
        image[word_of(32'h144)] = enc_jump(OP_B, 32'h144, 32'h120);
        image[word_of(32'h124)] = enc_jump(OP_B, 32'h124, 32'h160);
        image[word_of(32'h160)] = enc_jump(OP_B, 32'h160, 32'h160);
        // Four nested calls
        image[word_of(32'h204)] = enc_jump(OP_BL, 32'h204, 32'h240);
        image[word_of(32'h20c)] = enc_jump(OP_B, 32'h20c, 32'h20c);
        image[word_of(32'h244)] = enc_jump(OP_BL, 32'h244, 32'h280);
        image[word_of(32'h248)] = RET_WORD;
        image[word_of(32'h280)] = enc_jump(OP_BL, 32'h280, 32'h2c0);
        image[word_of(32'h284)] = RET_WORD;
        image[word_of(32'h2c0)] = enc_jump(OP_BL, 32'h2c0, 32'h300);
        image[word_of(32'h2c4)] = RET_WORD;
        image[word_of(32'h304)] = RET_WORD;
        image[word_of(32'h390)] = enc_jump(OP_B, 32'h390, 32'h390);
    endtask

    task automatic load_word(input virt_t addr, input u32_t data);
        @(negedge clk);
        load_valid = 1'b1;
        load_addr  = addr;
        load_data  = data;
    endtask

    task automatic flush_to(input virt_t pc);
        @(negedge clk);
        flush    = 1'b1;
        flush_pc = pc;
        @(negedge clk);
        flush    = 1'b0;
    endtask

    task automatic train_entry(input virt_t pc, input virt_t target);
        @(negedge clk);
        train_valid  = 1'b1;
        train_pc     = pc;
        train_target = target;
        @(negedge clk);
        train_valid  = 1'b0;
    endtask

    task automatic wait_for_pc(input virt_t pc, input int limit);
        int n;
        bit found;
        if (timed_out) begin
            return;
        end
        n     = 0;
        found = 1'b0;
        while (!found && n < limit) begin
            @(posedge clk);
            if (out_valid && out_ready && out_pc == pc) begin
                found = 1'b1;
            end
            n++;
        end
        if (!found) begin
            $display("Timeout: PC %h was never delivered on the decode port", pc);
            timeouts++;
            timed_out = 1'b1;
        end
        @(negedge clk);
    endtask

    initial begin
        clk          = 1'b0;
        rst_n        = 1'b1;
        flush        = 1'b0;
        flush_pc     = '0;
        train_valid  = 1'b0;
        train_pc     = '0;
        train_target = '0;
        load_valid   = 1'b0;
        load_addr    = '0;
        load_data    = '0;
        out_ready    = 1'b0;
        ready_en     = 1'b0;
        test_id      = 3'd0;
        timed_out    = 1'b0;
        timeouts     = 0;
        seed         = 30;

        build_image();
        for (k = 0; k < WORDS; k++) begin
            load_word(k << 2, image[k]);
        end
        @(negedge clk);
        load_valid = 1'b0;
        rst_n      = 1'b0;
        repeat (4) @(negedge clk);
        rst_n    = 1'b1;
        ready_en = 1'b1;

        test_id = 3'd1;
        wait_for_pc(32'h040, 300);

        test_id = 3'd2;
        flush_to(32'h100);
        wait_for_pc(32'h160, 300);

        test_id = 3'd3;
        flush_to(32'h200);
        wait_for_pc(32'h20c, 400);

        // Far target at a plain word, walked twice
        test_id = 3'd4;
        train_entry(32'h380, 32'h3f0);
        flush_to(32'h370);
        wait_for_pc(32'h390, 300);
        flush_to(32'h370);
        wait_for_pc(32'h390, 300);

        test_id = 3'd5;
        flush_to(32'h000);
        wait_for_pc(32'h014, 300);
        flush_to(32'h140);
        wait_for_pc(32'h160, 300);

        repeat (4) @(negedge clk);
        $display("Error counts: %0d compare, %0d timeout", err_count, timeouts);
        if (err_count == 0 && timeouts == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

/* sim.f */
+incdir+.
frontend_pkg.sv
btb.sv
ras.sv
inst_mem.sv
pc_gen.sv
fetch2.sv
frontend_top.sv
frontend_checker.sv
tb_frontend.sv

/* Bender.yml */
package:
  name: frontend

sources:
  - include_dirs:
      - .
    files:
      - frontend_pkg.sv
      - btb.sv
      - ras.sv
      - inst_mem.sv
      - pc_gen.sv
      - fetch2.sv
      - frontend_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - frontend_checker.sv
      - tb_frontend.sv
